// File: build.f
src/dbg_pkg.sv
src/inst_mem.sv
src/imem_arbiter.sv
src/cpu_core.sv
src/debug_unit.sv
src/debug_top.sv
verif/debug_checker.sv
verif/tb_debug_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module tb_debug_top -o sim_debug_top
out=$(./obj_dir/sim_debug_top)
echo "$out"
if echo "$out" | grep -q "Result: PASSED"; then
	exit 0
fi
exit 1

// File: src/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core
(
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               run,
	input  wire                               step,
	input  wire                               core_clear,
	input  wire                               core_gnt,
	input  wire  [dbg_pkg::data_width-1:0]    core_rdata,
	input  wire                               core_rvalid,
	output logic                              core_req,
	output logic [dbg_pkg::addr_width-1:0]    core_addr,
	output logic                              retired,
	output logic [dbg_pkg::addr_width-1:0]    pc,
	output logic [dbg_pkg::data_width-1:0]    acc,
	output logic                              halted
);

	logic [1:0]          state;
	dbg_pkg::inst_word_u fetched;
	logic [dbg_pkg::data_width-1:0] imm_ext;

	assign fetched   = core_rdata;
	assign imm_ext   = {{(dbg_pkg::data_width-dbg_pkg::imm_width){1'b0}}, fetched.fields.imm};
	assign core_req  = (state == dbg_pkg::cs_req);
	assign core_addr = pc;

	always_ff @(posedge clk)
	begin
		retired <= 1'b0;
		if (reset || core_clear)
		begin
			state  <= dbg_pkg::cs_idle;
			pc     <= '0;
			acc    <= '0;
			halted <= 1'b0;
		end
		else
		begin
			case (state)
				dbg_pkg::cs_idle:
				begin
					if (!halted && (run || step))
						state <= dbg_pkg::cs_req;
				end
				dbg_pkg::cs_req:
				begin
					if (core_gnt)
						state <= dbg_pkg::cs_wait;
				end
				dbg_pkg::cs_wait:
				begin
					if (core_rvalid)
					begin
						retired <= 1'b1;	// also for halt
						case (fetched.fields.opcode)
							dbg_pkg::op_addi: acc <= acc + imm_ext;
							dbg_pkg::op_xori: acc <= acc ^ imm_ext;
							default: ;
						endcase
						if (fetched.fields.opcode == dbg_pkg::op_halt)
						begin
							halted <= 1'b1;	// pc stays on the halt word
							state  <= dbg_pkg::cs_idle;
						end
						else
						begin
							pc    <= pc + 1'b1;
							state <= run ? dbg_pkg::cs_req : dbg_pkg::cs_idle;
						end
					end
				end
				default: state <= dbg_pkg::cs_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

	////////////////////////////////////////
	// widths
	localparam int data_width   = 32;	// instruction and accumulator word
	localparam int byte_width   = 8;	// host byte
	localparam int mem_depth    = 64;
	localparam int addr_width   = 6;
	localparam int opcode_width = 6;
	localparam int imm_width    = 16;

	////////////////////////////////////////
	// host command bytes
	localparam logic [byte_width-1:0] cmd_start      = 8'd1;
	localparam logic [byte_width-1:0] cmd_continuous = 8'd2;
	localparam logic [byte_width-1:0] cmd_step_mode  = 8'd3;
	localparam logic [byte_width-1:0] cmd_reprogram  = 8'd5;
	localparam logic [byte_width-1:0] cmd_step       = 8'd6;
	localparam logic [byte_width-1:0] cmd_peek       = 8'd7;

	// opcodes, anything else is a no-op
	localparam logic [opcode_width-1:0] op_addi = 6'd1;
	localparam logic [opcode_width-1:0] op_xori = 6'd2;
	localparam logic [opcode_width-1:0] op_halt = 6'h3f;

	////////////////////////////////////////
	// debug unit states
	localparam logic [2:0] st_idle      = 3'd0;
	localparam logic [2:0] st_prog      = 3'd1;	// byte loading
	localparam logic [2:0] st_wait      = 3'd2;
	localparam logic [2:0] st_step      = 3'd3;
	localparam logic [2:0] st_cont      = 3'd4;
	localparam logic [2:0] st_peek_addr = 3'd5;
	localparam logic [2:0] st_peek_read = 3'd6;
	localparam logic [2:0] st_send      = 3'd7;

	// core fetch states
	localparam logic [1:0] cs_idle = 2'd0;
	localparam logic [1:0] cs_req  = 2'd1;	// request held until granted
	localparam logic [1:0] cs_wait = 2'd2;	// read data due

	// one instruction word seen as host bytes or as decoded fields
	typedef union packed {
		logic [3:0][byte_width-1:0] bytes;	// index 0 is least significant
		struct packed {
			logic [opcode_width-1:0] opcode;
			logic [9:0]              rsvd;
			logic [imm_width-1:0]    imm;
		} fields;
	} inst_word_u;

endpackage

`default_nettype wire

// File: src/debug_top.sv
`timescale 1ns/1ps
`default_nettype none

module debug_top
(
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               rx_done_tick,
	input  wire  [dbg_pkg::byte_width-1:0]    rx_data,
	input  wire                               tx_done_tick,
	output logic                              tx_start,
	output logic [dbg_pkg::byte_width-1:0]    tx_data,
	output logic                              halted,
	output logic                              loading
);

	////////////////////////////////////////
	// debug port
	logic                           dbg_req;
	logic                           dbg_we;
	logic [dbg_pkg::addr_width-1:0] dbg_addr;
	logic [dbg_pkg::data_width-1:0] dbg_wdata;
	logic                           dbg_gnt;
	logic [dbg_pkg::data_width-1:0] dbg_rdata;
	logic                           dbg_rvalid;

	// core port and control
	logic                           core_req;
	logic [dbg_pkg::addr_width-1:0] core_addr;
	logic                           core_gnt;
	logic [dbg_pkg::data_width-1:0] core_rdata;
	logic                           core_rvalid;
	logic                           run;
	logic                           step;
	logic                           core_clear;
	logic                           retired;
	logic [dbg_pkg::addr_width-1:0] core_pc;
	logic [dbg_pkg::data_width-1:0] core_acc;

	// memory side
	logic                           mem_en;
	logic                           mem_we;
	logic [dbg_pkg::addr_width-1:0] mem_addr;
	logic [dbg_pkg::data_width-1:0] mem_wdata;
	logic [dbg_pkg::data_width-1:0] mem_rdata;

	debug_unit i_debug_unit (
		.clk(clk), .reset(reset),
		.rx_done_tick(rx_done_tick), .rx_data(rx_data), .tx_done_tick(tx_done_tick),
		.dbg_gnt(dbg_gnt), .dbg_rdata(dbg_rdata), .dbg_rvalid(dbg_rvalid),
		.retired(retired), .core_pc(core_pc), .core_acc(core_acc), .halted(halted),
		.tx_start(tx_start), .tx_data(tx_data),
		.dbg_req(dbg_req), .dbg_we(dbg_we), .dbg_addr(dbg_addr), .dbg_wdata(dbg_wdata),
		.run(run), .step(step), .core_clear(core_clear), .loading(loading)
	);

	cpu_core i_cpu_core (
		.clk(clk), .reset(reset),
		.run(run), .step(step), .core_clear(core_clear),
		.core_gnt(core_gnt), .core_rdata(core_rdata), .core_rvalid(core_rvalid),
		.core_req(core_req), .core_addr(core_addr), .retired(retired),
		.pc(core_pc), .acc(core_acc), .halted(halted)
	);

	imem_arbiter i_imem_arbiter (
		.clk(clk), .reset(reset),
		.dbg_req(dbg_req), .dbg_we(dbg_we), .dbg_addr(dbg_addr), .dbg_wdata(dbg_wdata),
		.core_req(core_req), .core_addr(core_addr), .mem_rdata(mem_rdata),
		.dbg_gnt(dbg_gnt), .dbg_rdata(dbg_rdata), .dbg_rvalid(dbg_rvalid),
		.core_gnt(core_gnt), .core_rdata(core_rdata), .core_rvalid(core_rvalid),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	inst_mem i_inst_mem (
		.clk(clk),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// File: src/debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit
(
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               rx_done_tick,
	input  wire  [dbg_pkg::byte_width-1:0]    rx_data,
	input  wire                               tx_done_tick,
	input  wire                               dbg_gnt,
	input  wire  [dbg_pkg::data_width-1:0]    dbg_rdata,
	input  wire                               dbg_rvalid,
	input  wire                               retired,
	input  wire  [dbg_pkg::addr_width-1:0]    core_pc,
	input  wire  [dbg_pkg::data_width-1:0]    core_acc,
	input  wire                               halted,
	output logic                              tx_start,
	output logic [dbg_pkg::byte_width-1:0]    tx_data,
	output logic                              dbg_req,
	output logic                              dbg_we,
	output logic [dbg_pkg::addr_width-1:0]    dbg_addr,
	output logic [dbg_pkg::data_width-1:0]    dbg_wdata,
	output logic                              run,
	output logic                              step,
	output logic                              core_clear,
	output logic                              loading
);

	logic [2:0]                     state;
	logic [2:0]                     ret_state;	// mode to go back to after a reply
	logic [1:0]                     byte_cnt;
	logic [dbg_pkg::addr_width-1:0] wr_addr;
	logic                           step_busy;	// waiting for retired
	logic [1:0]                     send_idx;
	logic [1:0]                     send_last;
	logic                           report_now;
	logic                           peek_done;
	dbg_pkg::inst_word_u            inst_q;
	dbg_pkg::inst_word_u            send_buf;

	// pc/acc report is due this cycle
	assign report_now = (state == dbg_pkg::st_cont && halted)
		|| (state == dbg_pkg::st_step && step_busy && retired)
		|| (state == dbg_pkg::st_step && !step_busy && rx_done_tick
			&& rx_data == dbg_pkg::cmd_step && halted);
	assign peek_done  = (state == dbg_pkg::st_peek_read) && dbg_rvalid;

	assign dbg_wdata  = inst_q;
	assign tx_data    = send_buf.bytes[send_idx];

	////////////////////////////////////////
	// payload registers
	always_ff @(posedge clk)
	begin
		if (state == dbg_pkg::st_prog && rx_done_tick)
			inst_q.bytes[byte_cnt] <= rx_data;	// lsb first
		if (state == dbg_pkg::st_peek_addr && rx_done_tick)
			dbg_addr <= rx_data[dbg_pkg::addr_width-1:0];
		else if (state == dbg_pkg::st_prog && rx_done_tick && byte_cnt == 2'd3)
			dbg_addr <= wr_addr;
		if (peek_done)
		begin
			send_buf  <= dbg_rdata;
			send_last <= 2'd3;
		end
		else if (report_now)
		begin
			send_buf.bytes[0] <= {{(dbg_pkg::byte_width-dbg_pkg::addr_width){1'b0}}, core_pc};
			send_buf.bytes[1] <= core_acc[dbg_pkg::byte_width-1:0];
			send_last         <= 2'd1;
		end
	end

	////////////////////////////////////////
	// host command FSM
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= dbg_pkg::st_idle;
			ret_state  <= dbg_pkg::st_idle;
			byte_cnt   <= '0;
			wr_addr    <= '0;
			step_busy  <= 1'b0;
			send_idx   <= '0;
			tx_start   <= 1'b0;
			dbg_req    <= 1'b0;
			dbg_we     <= 1'b0;
			run        <= 1'b0;
			step       <= 1'b0;
			core_clear <= 1'b0;
			loading    <= 1'b0;
		end
		else
		begin
			step       <= 1'b0;
			core_clear <= 1'b0;
			case (state)
				dbg_pkg::st_idle:
				begin
					if (rx_done_tick && rx_data == dbg_pkg::cmd_start)
					begin
						core_clear <= 1'b1;
						loading    <= 1'b1;
						byte_cnt   <= '0;
						wr_addr    <= '0;
						state      <= dbg_pkg::st_prog;
					end
				end
				dbg_pkg::st_prog:
				begin
					if (dbg_req && dbg_gnt)
					begin
						dbg_req <= 1'b0;	// word written
						wr_addr <= wr_addr + 1'b1;
						if (inst_q.fields.opcode == dbg_pkg::op_halt)
						begin
							loading <= 1'b0;
							state   <= dbg_pkg::st_wait;
						end
					end
					else if (rx_done_tick)
					begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == 2'd3)
						begin
							dbg_req <= 1'b1;
							dbg_we  <= 1'b1;
						end
					end
				end
				dbg_pkg::st_wait:
				begin
					if (rx_done_tick)
					begin
						case (rx_data)
							dbg_pkg::cmd_continuous:
							begin
								run   <= 1'b1;
								state <= dbg_pkg::st_cont;
							end
							dbg_pkg::cmd_step_mode: state <= dbg_pkg::st_step;
							dbg_pkg::cmd_peek:
							begin
								ret_state <= dbg_pkg::st_wait;
								state     <= dbg_pkg::st_peek_addr;
							end
							dbg_pkg::cmd_reprogram: state <= dbg_pkg::st_idle;
							default: ;	// ignored
						endcase
					end
				end
				dbg_pkg::st_step:
				begin
					if (step_busy)
					begin
						if (retired)
							step_busy <= 1'b0;
					end
					else if (rx_done_tick)
					begin
						case (rx_data)
							dbg_pkg::cmd_step:
							begin
								ret_state <= dbg_pkg::st_step;
								if (!halted)
								begin
									step      <= 1'b1;
									step_busy <= 1'b1;
								end
							end
							dbg_pkg::cmd_peek:
							begin
								ret_state <= dbg_pkg::st_step;
								state     <= dbg_pkg::st_peek_addr;
							end
							dbg_pkg::cmd_reprogram: state <= dbg_pkg::st_idle;
							default: ;
						endcase
					end
				end
				dbg_pkg::st_cont:
				begin
					if (halted)
					begin
						run       <= 1'b0;
						ret_state <= dbg_pkg::st_wait;
					end
					else if (rx_done_tick)
					begin
						case (rx_data)
							dbg_pkg::cmd_peek:
							begin
								ret_state <= dbg_pkg::st_cont;	// run stays high
								state     <= dbg_pkg::st_peek_addr;
							end
							dbg_pkg::cmd_reprogram:
							begin
								run   <= 1'b0;
								state <= dbg_pkg::st_idle;
							end
							default: ;
						endcase
					end
				end
				dbg_pkg::st_peek_addr:
				begin
					if (rx_done_tick)
					begin
						dbg_req <= 1'b1;
						dbg_we  <= 1'b0;
						state   <= dbg_pkg::st_peek_read;
					end
				end
				dbg_pkg::st_peek_read:
				begin
					if (dbg_req && dbg_gnt)
						dbg_req <= 1'b0;
				end
				dbg_pkg::st_send:
				begin
					if (tx_start)
					begin
						if (tx_done_tick)
						begin
							tx_start <= 1'b0;	// at least one idle cycle between bytes
							if (send_idx == send_last)
								state <= ret_state;
							else
								send_idx <= send_idx + 1'b1;
						end
					end
					else
						tx_start <= 1'b1;
				end
				default: state <= dbg_pkg::st_idle;
			endcase

			// both kinds of reply go out through st_send
			if (report_now || peek_done)
			begin
				send_idx <= '0;
				state    <= dbg_pkg::st_send;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/imem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module imem_arbiter
(
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               dbg_req,
	input  wire                               dbg_we,
	input  wire  [dbg_pkg::addr_width-1:0]    dbg_addr,
	input  wire  [dbg_pkg::data_width-1:0]    dbg_wdata,
	input  wire                               core_req,
	input  wire  [dbg_pkg::addr_width-1:0]    core_addr,
	input  wire  [dbg_pkg::data_width-1:0]    mem_rdata,
	output logic                              dbg_gnt,
	output logic [dbg_pkg::data_width-1:0]    dbg_rdata,
	output logic                              dbg_rvalid,
	output logic                              core_gnt,
	output logic [dbg_pkg::data_width-1:0]    core_rdata,
	output logic                              core_rvalid,
	output logic                              mem_en,
	output logic                              mem_we,
	output logic [dbg_pkg::addr_width-1:0]    mem_addr,
	output logic [dbg_pkg::data_width-1:0]    mem_wdata
);

	logic rd_pending;	// read issued last cycle
	logic owner_dbg;	// who issued it

	////////////////////////////////////////
	// grant, debug port always wins
	assign dbg_gnt   = dbg_req;
	assign core_gnt  = core_req && !dbg_req;

	assign mem_en    = dbg_req || core_req;
	assign mem_we    = dbg_req && dbg_we;	// core never writes
	assign mem_addr  = dbg_req ? dbg_addr : core_addr;
	assign mem_wdata = dbg_wdata;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_pending <= 1'b0;
			owner_dbg  <= 1'b0;
		end
		else
		begin
			rd_pending <= mem_en && !mem_we;
			owner_dbg  <= dbg_req;
		end
	end

	////////////////////////////////////////
	// return path
	assign dbg_rvalid  = rd_pending && owner_dbg;
	assign core_rvalid = rd_pending && !owner_dbg;
	assign dbg_rdata   = owner_dbg ? mem_rdata : '0;
	assign core_rdata  = owner_dbg ? '0 : mem_rdata;

endmodule

`default_nettype wire

// File: src/inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module inst_mem
(
	input  wire                               clk,
	input  wire                               mem_en,
	input  wire                               mem_we,
	input  wire  [dbg_pkg::addr_width-1:0]    mem_addr,
	input  wire  [dbg_pkg::data_width-1:0]    mem_wdata,
	output logic [dbg_pkg::data_width-1:0]    mem_rdata
);

	logic [dbg_pkg::data_width-1:0] mem [0:dbg_pkg::mem_depth-1];

	// single port, write has priority over read
	always_ff @(posedge clk)
	begin
		if (mem_en)
		begin
			if (mem_we)
				mem[mem_addr] <= mem_wdata;
			else
				mem_rdata <= mem[mem_addr];	// valid next cycle
		end
	end

endmodule

`default_nettype wire

// File: verif/debug_checker.sv
`timescale 1ns/1ps
`default_nettype none

module debug_checker
(
	input  wire        clk,
	input  wire        reset,
	input  wire        rx_done_tick,
	input  wire  [7:0] rx_data,
	input  wire        tx_start,
	input  wire  [7:0] tx_data,
	input  wire        tx_done_tick,
	input  wire        halted,
	input  wire        loading,
	input  wire        test_end,
	input  wire  [3:0] test_id,
	output int         error_count,
	output int         byte_count
);

	logic [31:0] mem [0:63];	// image rebuilt from host bytes
	logic [31:0] asm_word;
	int          asm_cnt;
	logic [5:0]  wr_addr;
	logic [5:0]  m_pc;
	logic [31:0] m_acc;
	logic        m_halted;
	logic [2:0]  c_state;	// host command state as the DUT should see it
	logic [2:0]  c_ret;
	logic [7:0]  exp_q [$];	// step and peek replies
	logic [7:0]  halt_q [$];	// continuous report sent after any peek
	int          errs_at_start;

	////////////////////////////////////////
	// model core
	task automatic exec_one();
		logic [5:0]  op;
		logic [31:0] imm;
		op  = mem[m_pc][31:26];
		imm = {16'h0000, mem[m_pc][15:0]};
		if (op == dbg_pkg::op_addi)
			m_acc = m_acc + imm;
		else if (op == dbg_pkg::op_xori)
			m_acc = m_acc ^ imm;
		if (op == dbg_pkg::op_halt)
			m_halted = 1'b1;	// pc stays on the halt word
		else
			m_pc = m_pc + 6'd1;
	endtask

	task automatic run_to_halt();
		int guard;
		guard = 0;
		while (!m_halted && guard < 256)
		begin
			exec_one();
			guard++;
		end
	endtask

	task automatic check_flags();
		logic exp_loading;
		exp_loading = (c_state == dbg_pkg::st_prog);
		if (loading !== exp_loading)
		begin
			$display("Fail loading: expected 0x%0h, actual 0x%0h", exp_loading, loading);
			error_count++;
		end
		// during a run the DUT halts later than the model
		if (c_state != dbg_pkg::st_cont
			&& !(c_state == dbg_pkg::st_peek_addr && c_ret == dbg_pkg::st_cont)
			&& halted !== m_halted)
		begin
			$display("Fail halted: expected 0x%0h, actual 0x%0h", m_halted, halted);
			error_count++;
		end
	endtask

	////////////////////////////////////////
	// host bytes in
	task automatic take_rx(input logic [7:0] b);
		logic [31:0] w;
		check_flags();
		case (c_state)
			dbg_pkg::st_idle:
			begin
				if (b == dbg_pkg::cmd_start)
				begin
					m_pc     = '0;
					m_acc    = '0;
					m_halted = 1'b0;
					asm_cnt  = 0;
					wr_addr  = '0;
					c_state  = dbg_pkg::st_prog;
				end
			end
			dbg_pkg::st_prog:
			begin
				asm_word[asm_cnt*8 +: 8] = b;	// lsb first
				asm_cnt++;
				if (asm_cnt == 4)
				begin
					mem[wr_addr] = asm_word;
					wr_addr      = wr_addr + 6'd1;
					asm_cnt      = 0;
					if (asm_word[31:26] == dbg_pkg::op_halt)
						c_state = dbg_pkg::st_wait;
				end
			end
			dbg_pkg::st_wait:
			begin
				if (b == dbg_pkg::cmd_continuous)
				begin
					run_to_halt();
					halt_q.push_back({2'b00, m_pc});
					halt_q.push_back(m_acc[7:0]);
					c_state = dbg_pkg::st_cont;
				end
				else if (b == dbg_pkg::cmd_step_mode)
					c_state = dbg_pkg::st_step;
				else if (b == dbg_pkg::cmd_peek)
				begin
					c_ret   = dbg_pkg::st_wait;
					c_state = dbg_pkg::st_peek_addr;
				end
				else if (b == dbg_pkg::cmd_reprogram)
					c_state = dbg_pkg::st_idle;
			end
			dbg_pkg::st_step:
			begin
				if (b == dbg_pkg::cmd_step)
				begin
					if (!m_halted)
						exec_one();
					exp_q.push_back({2'b00, m_pc});
					exp_q.push_back(m_acc[7:0]);
				end
				else if (b == dbg_pkg::cmd_peek)
				begin
					c_ret   = dbg_pkg::st_step;
					c_state = dbg_pkg::st_peek_addr;
				end
				else if (b == dbg_pkg::cmd_reprogram)
					c_state = dbg_pkg::st_idle;
			end
			dbg_pkg::st_cont:
			begin
				if (b == dbg_pkg::cmd_peek)
				begin
					c_ret   = dbg_pkg::st_cont;
					c_state = dbg_pkg::st_peek_addr;
				end
			end
			dbg_pkg::st_peek_addr:
			begin
				w = mem[b[5:0]];
				for (int k = 0; k < 4; k++)
					exp_q.push_back(w[k*8 +: 8]);
				c_state = c_ret;
			end
			default: ;
		endcase
	endtask

	////////////////////////////////////////
	// report bytes out
	task automatic take_tx(input logic [7:0] b);
		logic [7:0] e;
		byte_count++;
		if (exp_q.size() > 0)
			e = exp_q.pop_front();
		else if (halt_q.size() > 0)
		begin
			e = halt_q.pop_front();
			if (halt_q.size() == 0)
				c_state = dbg_pkg::st_wait;	// halt report done
		end
		else
		begin
			$display("DUT sent byte 0x%02h when no reply was due", b);
			error_count++;
			return;
		end
		if (b !== e)
		begin
			$display("Fail tx_data: expected 0x%02h, actual 0x%02h", e, b);
			error_count++;
		end
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			c_state       = dbg_pkg::st_idle;
			c_ret         = dbg_pkg::st_idle;
			m_pc          = '0;
			m_acc         = '0;
			m_halted      = 1'b0;
			asm_cnt       = 0;
			wr_addr       = '0;
			error_count   = 0;
			byte_count    = 0;
			errs_at_start = 0;
			exp_q.delete();
			halt_q.delete();
		end
		else
		begin
			if (rx_done_tick)
				take_rx(rx_data);
			if (tx_start && tx_done_tick)
				take_tx(tx_data);
			if (test_end)
			begin
				if (exp_q.size() + halt_q.size() > 0)
				begin
					$display("test %0d: %0d reply bytes were due but never sent", test_id,
						exp_q.size() + halt_q.size());
					error_count++;
					exp_q.delete();
					halt_q.delete();
				end
				if (error_count == errs_at_start)
					$display("test %0d: ok", test_id);
				else
					$display("test %0d: %0d errors", test_id, error_count - errs_at_start);
				errs_at_start = error_count;
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_debug_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debug_top;

	logic        clk;
	logic        reset;
	logic        rx_done_tick;
	logic [7:0]  rx_data;
	logic        tx_done_tick;
	logic        test_end;
	logic [3:0]  test_id;
	wire         tx_start;
	wire  [7:0]  tx_data;
	wire         halted;
	wire         loading;
	int          error_count;
	int          byte_count;
	integer      seed;
	int          tx_count;
	int          exp_tx;
	int          wd_cycles;
	int          prog_len;
	logic [31:0] prog [0:20];

	debug_top i_debug_top (
		.clk(clk), .reset(reset),
		.rx_done_tick(rx_done_tick), .rx_data(rx_data), .tx_done_tick(tx_done_tick),
		.tx_start(tx_start), .tx_data(tx_data), .halted(halted), .loading(loading)
	);

	debug_checker i_checker (
		.clk(clk), .reset(reset),
		.rx_done_tick(rx_done_tick), .rx_data(rx_data),
		.tx_start(tx_start), .tx_data(tx_data), .tx_done_tick(tx_done_tick),
		.halted(halted), .loading(loading), .test_end(test_end), .test_id(test_id),
		.error_count(error_count), .byte_count(byte_count)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		if (reset)
			tx_count <= 0;
		else if (tx_start && tx_done_tick)
			tx_count <= tx_count + 1;
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'({$random(seed)} % (hi - lo + 1));
	endfunction

	////////////////////////////////////////
	// host side
	task automatic send_byte(input logic [7:0] b, input int gap);
		repeat (gap) @(negedge clk);
		rx_data      = b;
		rx_done_tick = 1'b1;
		@(negedge clk);
		rx_done_tick = 1'b0;
	endtask

	task automatic send_cmd(input logic [7:0] b);
		send_byte(b, rand_range(6, 12));
	endtask

	task automatic load_program(input int n);
		logic [31:0] r;
		logic [5:0]  op;
		for (int i = 0; i < n; i++)
		begin
			r = $random(seed);
			case (rand_range(0, 2))
				0: op = dbg_pkg::op_addi;
				1: op = dbg_pkg::op_xori;
				default: op = 6'h10;	// no-op
			endcase
			prog[i] = {op, r[25:0]};
		end
		r = $random(seed);
		prog[n]  = {dbg_pkg::op_halt, r[25:0]};
		prog_len = n + 1;
		send_cmd(dbg_pkg::cmd_start);
		for (int i = 0; i < prog_len; i++)
			for (int k = 0; k < 4; k++)
				send_cmd(prog[i][k*8 +: 8]);
	endtask

	task automatic expect_replies(input int n);
		exp_tx += n;
		while (tx_count < exp_tx)
			@(negedge clk);
	endtask

	task automatic finish_test(input int id);
		repeat (4) @(negedge clk);
		test_id  = id[3:0];
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	// transmit done after a random delay
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (tx_start && !reset)
			begin
				repeat (rand_range(1, 20)) @(negedge clk);
				tx_done_tick = 1'b1;
				@(negedge clk);
				tx_done_tick = 1'b0;
			end
		end
	end

	// watchdog, bound from the longest test times the test count
	initial
	begin
		wd_cycles = 6 * (21 * 4 + 21 * 6 + 30) * 40 + 5000;
		repeat (wd_cycles) @(posedge clk);
		$display("timeout: the DUT stopped replying");
		$display("Result: FAILED");
		$finish;
	end

	////////////////////////////////////////
	// tests
	initial
	begin
		seed         = 32'hb1b1;
		reset        = 1'b1;
		rx_done_tick = 1'b0;
		rx_data      = 8'h00;
		tx_done_tick = 1'b0;
		test_end     = 1'b0;
		test_id      = 4'd0;
		exp_tx       = 0;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		load_program(rand_range(4, 20));	// load and continuous run
		send_cmd(dbg_pkg::cmd_continuous);
		expect_replies(2);
		finish_test(1);

		send_cmd(dbg_pkg::cmd_reprogram);	// step mode, past the halt
		load_program(rand_range(4, 20));
		send_cmd(dbg_pkg::cmd_step_mode);
		for (int i = 0; i < prog_len + 2; i++)
		begin
			send_cmd(dbg_pkg::cmd_step);
			expect_replies(2);
		end
		finish_test(2);

		for (int a = 0; a < prog_len; a++)	// peek every loaded word
		begin
			send_cmd(dbg_pkg::cmd_peek);
			send_cmd(a[7:0]);
			expect_replies(4);
		end
		finish_test(3);

		send_cmd(dbg_pkg::cmd_reprogram);	// peek while the core runs
		load_program(20);
		send_cmd(dbg_pkg::cmd_continuous);
		send_byte(dbg_pkg::cmd_peek, 6);
		send_byte(8'(rand_range(0, 20)), 6);
		expect_replies(6);
		finish_test(4);

		send_cmd(dbg_pkg::cmd_reprogram);	// reprogram with junk bytes around
		send_cmd(8'h44);
		load_program(rand_range(4, 20));
		send_cmd(8'ha5);
		send_cmd(dbg_pkg::cmd_step);
		repeat (60) @(negedge clk);
		send_cmd(dbg_pkg::cmd_continuous);
		expect_replies(2);
		finish_test(5);

		send_cmd(dbg_pkg::cmd_reprogram);	// loading and halted flags over a step run
		load_program(rand_range(4, 20));
		send_cmd(dbg_pkg::cmd_step_mode);
		for (int i = 0; i < prog_len; i++)
		begin
			send_cmd(dbg_pkg::cmd_step);
			expect_replies(2);
		end
		send_cmd(dbg_pkg::cmd_reprogram);
		finish_test(6);

		$display("6 tests, %0d reply bytes checked, %0d errors", byte_count, error_count);
		if (error_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
